// ==== dv/lin_tb_bus.svh ====
// Wishbone read/write tasks and LIN line driving tasks
// included inside the lin_tb module
`ifndef LIN_TB_BUS_SVH
`define LIN_TB_BUS_SVH

// one classic cycle, slave acks on the next edge
task automatic wb_access(input logic we, input logic [lin_regs_pkg::WB_AW-1:0] adr,
                         input logic [lin_regs_pkg::WB_DW-1:0] wdata,
                         output logic [lin_regs_pkg::WB_DW-1:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk_fin);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_i <= wdata;
    // ack and read data sampled mid cycle
    @(negedge clk_fin);
    while (!wb_ack && waited < ACK_LIMIT)
    begin
        @(negedge clk_fin);
        waited++;
    end
    assert (wb_ack)
    else
    begin
        $display("the DUT did not acknowledge the bus access to address %0d", adr);
        errors++;
    end
    rdata = wb_dat_o;
    // master releases the bus on the edge that ends the ack
    @(posedge clk_fin);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
endtask

task automatic wb_write(input logic [lin_regs_pkg::WB_AW-1:0] adr,
                        input logic [lin_regs_pkg::WB_DW-1:0] wdata);
    logic [lin_regs_pkg::WB_DW-1:0] unused;
    wb_access(1'b1, adr, wdata, unused);
endtask

task automatic wb_read(input logic [lin_regs_pkg::WB_AW-1:0] adr,
                       output logic [lin_regs_pkg::WB_DW-1:0] rdata);
    wb_access(1'b0, adr, '0, rdata);
endtask

// level stays on rxd for exactly the given number of clocks
task automatic hold_line(input logic level, input int cycles);
    @(posedge clk_fin);
    rxd <= level;
    repeat (cycles - 1) @(posedge clk_fin);
endtask

// 13 low bit times, then a one-bit delimiter
task automatic send_break(input int bit_cycles);
    hold_line(1'b0, 13 * bit_cycles);
    hold_line(1'b1, bit_cycles);
endtask

// 0x55 LSB first between a start bit and a stop bit
task automatic send_sync(input int bit_cycles);
    logic [9:0] frame;
    frame = {1'b1, 8'h55, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
        hold_line(frame[i], bit_cycles);
    end
endtask

`endif

// ==== dv/lin_tb.sv ====
// testbench for the LIN frame-start logic
// reset, pin gating, break and synch measurement, overrun, receive disable
`timescale 1ns/1ps

module lin_tb;

    localparam int BIT_CYCLES     = 16;
    localparam int TIMEOUT_CYCLES = 6 * (13 + 1 + 10) * BIT_CYCLES * 2 + 2000;
    localparam int ACK_LIMIT      = 8;

    logic                           clk_fin;
    logic                           rst;
    logic                           rxd;
    logic                           txd;
    logic                           rxd_out;
    logic                           txd_out;
    logic                           interrupt;
    logic                           wb_cyc;
    logic                           wb_stb;
    logic                           wb_we;
    logic [lin_regs_pkg::WB_AW-1:0] wb_adr;
    logic [lin_regs_pkg::WB_DW-1:0] wb_dat_i;
    logic [lin_regs_pkg::WB_DW-1:0] wb_dat_o;
    logic                           wb_ack;

    int     errors;
    int     checks;
    int     tests;
    int     test_errors;
    int     cycles;
    string  test_name;
    integer seed;

    lin_break_sync_top DUT (
        .clk_fin   (clk_fin),
        .rst       (rst),
        .rxd       (rxd),
        .txd       (txd),
        .rxd_out   (rxd_out),
        .txd_out   (txd_out),
        .interrupt (interrupt),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack)
    );

    `include "lin_tb_bus.svh"

    // 4 ns clock period
    always #2 clk_fin = ~clk_fin;

    task automatic check_eq(input string what, input logic [lin_regs_pkg::WB_DW-1:0] exp,
                            input logic [lin_regs_pkg::WB_DW-1:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s done with %0d errors", test_name, errors - test_errors);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_fin);
    endtask

    task automatic reset_and_regs();
        logic [lin_regs_pkg::WB_DW-1:0] rd;
        start_test("reset_and_regs");
        @(negedge clk_fin);
        check_eq("rxd_out", 1, rxd_out);
        check_eq("txd_out", 0, txd_out);
        check_eq("interrupt", 0, interrupt);
        wb_read(lin_regs_pkg::ADDR_CTRL, rd);
        check_eq("ctrl", 0, rd);
        wb_read(lin_regs_pkg::ADDR_STATUS, rd);
        check_eq("status", 0, rd);
        wb_read(lin_regs_pkg::ADDR_IMASK, rd);
        check_eq("imask", 0, rd);
        // only the three control bits and four mask bits exist
        wb_write(lin_regs_pkg::ADDR_CTRL, 16'hffff);
        wb_read(lin_regs_pkg::ADDR_CTRL, rd);
        check_eq("ctrl readback", 16'h0007, rd);
        wb_write(lin_regs_pkg::ADDR_IMASK, 16'hffff);
        wb_read(lin_regs_pkg::ADDR_IMASK, rd);
        check_eq("imask readback", 16'h000f, rd);
        wb_write(lin_regs_pkg::ADDR_CTRL, 16'h0000);
        wb_write(lin_regs_pkg::ADDR_IMASK, 16'h0000);
        end_test();
    endtask

    task automatic pin_gating();
        int   rnd;
        logic bit_val;
        logic prev;
        start_test("pin_gating");
        wb_write(lin_regs_pkg::ADDR_CTRL, 16'(1 << lin_regs_pkg::CTRL_START));
        prev = txd;
        for (int i = 0; i < 8; i++)
        begin
            rnd     = $random(seed);
            bit_val = rnd[0];
            @(posedge clk_fin);
            txd <= bit_val;
            // old value for one more cycle
            @(negedge clk_fin);
            check_eq("txd_out before", 16'(prev), 16'(txd_out));
            @(negedge clk_fin);
            check_eq("txd_out after", 16'(bit_val), 16'(txd_out));
            prev = bit_val;
        end
        wb_write(lin_regs_pkg::ADDR_CTRL,
                 16'((1 << lin_regs_pkg::CTRL_START) | (1 << lin_regs_pkg::CTRL_TXD_DIS)));
        for (int i = 0; i < 6; i++)
        begin
            @(posedge clk_fin);
            txd <= ~txd;
            @(negedge clk_fin);
            check_eq("txd_out disabled", 0, 16'(txd_out));
        end
        // short lows on rxd, no measurement yet so the gate stays shut
        for (int i = 0; i < 4; i++)
        begin
            hold_line(1'b0, 2);
            @(negedge clk_fin);
            check_eq("rxd_out closed low", 1, 16'(rxd_out));
            hold_line(1'b1, 2);
            @(negedge clk_fin);
            check_eq("rxd_out closed high", 1, 16'(rxd_out));
        end
        wb_write(lin_regs_pkg::ADDR_CTRL, 16'(1 << lin_regs_pkg::CTRL_START));
        txd <= 1'b0;
        end_test();
    endtask

    task automatic break_and_measure();
        logic [lin_regs_pkg::WB_DW-1:0] rd;
        start_test("break_and_measure");
        send_break(BIT_CYCLES);
        send_sync(BIT_CYCLES);
        wb_read(lin_regs_pkg::ADDR_STATUS, rd);
        check_eq("status", 16'((1 << lin_regs_pkg::STS_BREAK) | (1 << lin_regs_pkg::STS_EDGE)
                 | (1 << lin_regs_pkg::STS_SYNC)), rd);
        // eight bit times between the first and fifth falling edge
        wb_read(lin_regs_pkg::ADDR_SYNC, rd);
        check_eq("first sync", 16'(8 * BIT_CYCLES), rd);
        wb_read(lin_regs_pkg::ADDR_SYNC, rd);
        check_eq("empty sync", 0, rd);
        hold_line(1'b0, 3);
        @(negedge clk_fin);
        check_eq("rxd_out open low", 0, 16'(rxd_out));
        hold_line(1'b1, 3);
        @(negedge clk_fin);
        check_eq("rxd_out open high", 1, 16'(rxd_out));
        end_test();
    endtask

    task automatic short_low();
        logic [lin_regs_pkg::WB_DW-1:0] rd;
        start_test("short_low");
        // let the last edge pulse land before clearing
        idle_cycles(8);
        wb_write(lin_regs_pkg::ADDR_STATUS, 16'h000f);
        wb_read(lin_regs_pkg::ADDR_STATUS, rd);
        check_eq("status cleared", 0, rd);
        hold_line(1'b0, 5 * BIT_CYCLES);
        hold_line(1'b1, BIT_CYCLES);
        wb_read(lin_regs_pkg::ADDR_STATUS, rd);
        check_eq("status after low", 16'(1 << lin_regs_pkg::STS_EDGE), rd);
        end_test();
    endtask

    task automatic overrun_and_irq();
        logic [lin_regs_pkg::WB_DW-1:0] rd;
        int                             bit_times [5];
        start_test("overrun_and_irq");
        bit_times = '{12, 14, 16, 18, 20};
        // five measurements into a four-entry buffer
        for (int i = 0; i < 5; i++)
        begin
            send_break(bit_times[i]);
            send_sync(bit_times[i]);
        end
        wb_read(lin_regs_pkg::ADDR_STATUS, rd);
        check_eq("status", 16'h000f, rd);
        for (int i = 0; i < 4; i++)
        begin
            wb_read(lin_regs_pkg::ADDR_SYNC, rd);
            check_eq("sync order", 16'(8 * bit_times[i]), rd);
        end
        wb_write(lin_regs_pkg::ADDR_IMASK, 16'(1 << lin_regs_pkg::STS_OVERRUN));
        @(negedge clk_fin);
        check_eq("interrupt set", 1, 16'(interrupt));
        wb_write(lin_regs_pkg::ADDR_STATUS, 16'(1 << lin_regs_pkg::STS_OVERRUN));
        @(negedge clk_fin);
        check_eq("interrupt cleared", 0, 16'(interrupt));
        wb_write(lin_regs_pkg::ADDR_IMASK, 16'h0000);
        end_test();
    endtask

    task automatic receive_disable();
        logic [lin_regs_pkg::WB_DW-1:0] rd;
        start_test("receive_disable");
        send_break(BIT_CYCLES);
        send_sync(BIT_CYCLES);
        wb_read(lin_regs_pkg::ADDR_SYNC, rd);
        check_eq("sync", 16'(8 * BIT_CYCLES), rd);
        hold_line(1'b0, 3);
        @(negedge clk_fin);
        check_eq("rxd_out open", 0, 16'(rxd_out));
        // line stays low, far shorter than a break
        wb_write(lin_regs_pkg::ADDR_CTRL,
                 16'((1 << lin_regs_pkg::CTRL_START) | (1 << lin_regs_pkg::CTRL_RXD_DIS)));
        idle_cycles(2);
        @(negedge clk_fin);
        check_eq("rxd_out disabled", 1, 16'(rxd_out));
        wb_write(lin_regs_pkg::ADDR_CTRL, 16'(1 << lin_regs_pkg::CTRL_START));
        idle_cycles(2);
        @(negedge clk_fin);
        check_eq("rxd_out re-enabled", 1, 16'(rxd_out));
        hold_line(1'b1, BIT_CYCLES);
        // next measurement reopens the gate
        send_break(BIT_CYCLES);
        send_sync(BIT_CYCLES);
        hold_line(1'b0, 3);
        @(negedge clk_fin);
        check_eq("rxd_out reopened", 0, 16'(rxd_out));
        hold_line(1'b1, 4);
        end_test();
    endtask

    // run limit from the longest test sequence
    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk_fin);
            cycles++;
        end
        $display("timeout after %0d cycles, the test sequence did not finish", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        clk_fin  = 1'b0;
        rst      = 1'b1;
        rxd      = 1'b1;
        txd      = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        seed     = 32'h3795_395e;
        repeat (5) @(posedge clk_fin);
        rst <= 1'b0;
        reset_and_regs();
        pin_gating();
        break_and_measure();
        short_low();
        overrun_and_irq();
        receive_disable();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+dv
src/lin_proto_pkg.sv
src/lin_regs_pkg.sv
src/lin_frame_detector.sv
src/lin_sync_fifo.sv
src/lin_slave_regs.sv
src/lin_break_sync_top.sv
dv/lin_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the LIN frame-start testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lin_tb -f list.f -o lin_tb_sim \
    || { echo "build error"; exit 1; }

./obj_dir/lin_tb_sim > sim.log 2>&1
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== src/lin_break_sync_top.sv ====
// top level of the LIN slave frame-start logic
// detector, measurement FIFO and Wishbone register block
`timescale 1ns/1ps

module lin_break_sync_top #(
    parameter int BREAK_LEN  = 150,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                           clk_fin,
    input  logic                           rst,
    input  logic                           rxd,
    input  logic                           txd,
    output logic                           rxd_out,
    output logic                           txd_out,
    output logic                           interrupt,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [lin_regs_pkg::WB_AW-1:0] wb_adr,
    input  logic [lin_regs_pkg::WB_DW-1:0] wb_dat_i,
    output logic [lin_regs_pkg::WB_DW-1:0] wb_dat_o,
    output logic                           wb_ack
);

    logic                 enable;
    logic                 break_pulse;
    logic                 edge_pulse;
    logic                 meas_valid;
    lin_proto_pkg::meas_t meas_data;
    lin_proto_pkg::meas_t fifo_data;
    logic                 fifo_empty;
    logic                 fifo_pop;
    logic                 overrun;

    lin_frame_detector #(
        .BREAK_LEN (BREAK_LEN)
    ) u_detector (
        .clk_fin     (clk_fin),
        .rst         (rst),
        .rxd         (rxd),
        .enable      (enable),
        .break_pulse (break_pulse),
        .edge_pulse  (edge_pulse),
        .meas_valid  (meas_valid),
        .meas_data   (meas_data)
    );

    // measurements wait here until the CPU reads them
    lin_sync_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_fin    (clk_fin),
        .rst        (rst),
        .push       (meas_valid),
        .push_data  (meas_data),
        .pop        (fifo_pop),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .overrun    (overrun)
    );

    lin_slave_regs u_regs (
        .clk_fin     (clk_fin),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .txd         (txd),
        .rxd         (rxd),
        .break_pulse (break_pulse),
        .edge_pulse  (edge_pulse),
        .meas_valid  (meas_valid),
        .overrun     (overrun),
        .fifo_empty  (fifo_empty),
        .fifo_data   (fifo_data),
        .wb_dat_o    (wb_dat_o),
        .wb_ack      (wb_ack),
        .fifo_pop    (fifo_pop),
        .enable      (enable),
        .rxd_out     (rxd_out),
        .txd_out     (txd_out),
        .interrupt   (interrupt)
    );

endmodule

// ==== src/lin_frame_detector.sv ====
// LIN break, delimiter and synch field detector
// rxd synchronizer, edge pulse and auto-baud synch counter
`timescale 1ns/1ps

module lin_frame_detector #(
    parameter int BREAK_LEN = 150
) (
    input  logic                 clk_fin,
    input  logic                 rst,
    input  logic                 rxd,
    input  logic                 enable,
    output logic                 break_pulse,
    output logic                 edge_pulse,
    output logic                 meas_valid,
    output lin_proto_pkg::meas_t meas_data
);

    // low-run counter saturates at BREAK_LEN
    localparam int LW = $clog2(BREAK_LEN + 1);
    // falling edge counter inside the synch field
    localparam int FW = $clog2(lin_proto_pkg::SYNC_FALLS + 1);

    logic                     rxd_meta;
    logic                     rxd_sync;
    logic                     rxd_prev;
    logic                     fall;
    logic                     low_hit;
    logic [LW-1:0]            low_cnt;
    logic [FW-1:0]            fall_cnt;
    lin_proto_pkg::meas_t     sync_cnt;
    lin_proto_pkg::det_state_t state;

    // two-flop synchronizer, idle line is high
    always_ff @(posedge clk_fin)
    begin
        if (rst)
        begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end
        else
        begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall = rxd_prev & ~rxd_sync;

    // BREAK_LEN-th consecutive low clock
    assign low_hit = ~rxd_sync && (low_cnt == LW'(BREAK_LEN - 1));

    // length of the current low run, cleared on any high
    always_ff @(posedge clk_fin)
    begin
        if (rst || !enable || rxd_sync)
        begin
            low_cnt <= '0;
        end
        else if (low_cnt != LW'(BREAK_LEN))
        begin
            low_cnt <= low_cnt + 1'b1;
        end
    end

    // frame-start FSM
    always_ff @(posedge clk_fin)
    begin
        if (rst || !enable)
        begin
            state       <= lin_proto_pkg::IDLE;
            break_pulse <= 1'b0;
            edge_pulse  <= 1'b0;
            meas_valid  <= 1'b0;
            fall_cnt    <= '0;
            sync_cnt    <= '0;
        end
        else
        begin
            edge_pulse  <= rxd_sync ^ rxd_prev;
            break_pulse <= 1'b0;
            meas_valid  <= 1'b0;
            case (state)
                lin_proto_pkg::IDLE:
                begin
                    if (!rxd_sync)
                    begin
                        state <= lin_proto_pkg::BREAK;
                    end
                end
                lin_proto_pkg::BREAK:
                begin
                    if (low_hit)
                    begin
                        break_pulse <= 1'b1;
                    end
                    // high ends the low run, long enough means delimiter
                    if (rxd_sync)
                    begin
                        if (low_cnt == LW'(BREAK_LEN))
                        begin
                            state <= lin_proto_pkg::DELIM;
                        end
                        else
                        begin
                            state <= lin_proto_pkg::IDLE;
                        end
                    end
                end
                lin_proto_pkg::DELIM:
                begin
                    // start bit edge of the synch field opens the window
                    if (fall)
                    begin
                        state    <= lin_proto_pkg::SYNC_MEASURE;
                        fall_cnt <= '0;
                        sync_cnt <= lin_proto_pkg::meas_t'(1);
                    end
                end
                lin_proto_pkg::SYNC_MEASURE:
                begin
                    if (low_hit)
                    begin
                        // break inside the field restarts the search
                        break_pulse <= 1'b1;
                        state       <= lin_proto_pkg::DELIM;
                    end
                    else if (sync_cnt == '1)
                    begin
                        state <= lin_proto_pkg::IDLE;
                    end
                    else
                    begin
                        sync_cnt <= sync_cnt + 1'b1;
                        if (fall)
                        begin
                            if (fall_cnt == FW'(lin_proto_pkg::SYNC_FALLS - 1))
                            begin
                                meas_valid <= 1'b1;
                                state      <= lin_proto_pkg::IDLE;
                            end
                            else
                            begin
                                fall_cnt <= fall_cnt + 1'b1;
                            end
                        end
                    end
                end
                default:
                begin
                    state <= lin_proto_pkg::IDLE;
                end
            endcase
        end
    end

    // value captured on the closing edge, eight bit times
    always_ff @(posedge clk_fin)
    begin
        if (state == lin_proto_pkg::SYNC_MEASURE && fall)
        begin
            meas_data <= sync_cnt;
        end
    end

endmodule

// ==== src/lin_proto_pkg.sv ====
// line protocol definitions for the LIN frame-start logic
// synch measurement type and detector state encoding
package lin_proto_pkg;

    // width of one synch field measurement in clocks
    localparam int MEAS_W = 16;

    typedef logic [MEAS_W-1:0] meas_t;

    // falling edges of the 0x55 field after the start bit edge
    // fifth edge overall closes the eight bit times
    localparam int SYNC_FALLS = 4;

    // break/delimiter/synch detector states
    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        BREAK        = 3'd1,
        DELIM        = 3'd2,
        SYNC_MEASURE = 3'd3
    } det_state_t;

endpackage

// ==== src/lin_regs_pkg.sv ====
// register map of the LIN slave Wishbone port
// addresses, control and status bit positions, bus widths
package lin_regs_pkg;

    // wishbone data and address widths
    localparam int WB_DW = 16;
    localparam int WB_AW = 2;

    // word addresses
    localparam logic [WB_AW-1:0] ADDR_CTRL   = 2'd0;
    localparam logic [WB_AW-1:0] ADDR_STATUS = 2'd1;
    localparam logic [WB_AW-1:0] ADDR_IMASK  = 2'd2;
    localparam logic [WB_AW-1:0] ADDR_SYNC   = 2'd3;

    // control register bits
    localparam int CTRL_START   = 0;
    localparam int CTRL_TXD_DIS = 1;
    localparam int CTRL_RXD_DIS = 2;

    // status register bits
    // break, edge and overrun are sticky, sync is live
    localparam int STS_BREAK   = 0;
    localparam int STS_EDGE    = 1;
    localparam int STS_OVERRUN = 2;
    localparam int STS_SYNC    = 3;

    localparam int STS_W = 4;

endpackage

// ==== src/lin_slave_regs.sv ====
// Wishbone register block of the LIN slave
// control, sticky status, interrupt mask, synch readout and pin gating
`timescale 1ns/1ps

module lin_slave_regs (
    input  logic                                clk_fin,
    input  logic                                rst,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [lin_regs_pkg::WB_AW-1:0]      wb_adr,
    input  logic [lin_regs_pkg::WB_DW-1:0]      wb_dat_i,
    input  logic                                txd,
    input  logic                                rxd,
    input  logic                                break_pulse,
    input  logic                                edge_pulse,
    input  logic                                meas_valid,
    input  logic                                overrun,
    input  logic                                fifo_empty,
    input  lin_proto_pkg::meas_t                fifo_data,
    output logic [lin_regs_pkg::WB_DW-1:0]      wb_dat_o,
    output logic                                wb_ack,
    output logic                                fifo_pop,
    output logic                                enable,
    output logic                                rxd_out,
    output logic                                txd_out,
    output logic                                interrupt
);

    logic                              req;
    logic                              wr_en;
    logic                              rd_en;
    logic                              clr_sts;
    logic [lin_regs_pkg::CTRL_RXD_DIS:0] ctrl;
    logic [lin_regs_pkg::STS_W-1:0]    imask;
    logic [lin_regs_pkg::STS_W-1:0]    status;
    logic                              sts_break;
    logic                              sts_edge;
    logic                              sts_overrun;
    logic                              rxd_gate;
    logic [lin_regs_pkg::WB_DW-1:0]    rd_data;

    // new request, acked on the next edge
    assign req     = wb_cyc & wb_stb & ~wb_ack;
    assign wr_en   = req & wb_we;
    assign rd_en   = req & ~wb_we;
    assign clr_sts = wr_en && (wb_adr == lin_regs_pkg::ADDR_STATUS);

    // head leaves the FIFO on the edge its read data is captured
    assign fifo_pop = rd_en && (wb_adr == lin_regs_pkg::ADDR_SYNC) && !fifo_empty;

    assign enable = ctrl[lin_regs_pkg::CTRL_START];

    always_comb
    begin
        status = '0;
        status[lin_regs_pkg::STS_BREAK]   = sts_break;
        status[lin_regs_pkg::STS_EDGE]    = sts_edge;
        status[lin_regs_pkg::STS_OVERRUN] = sts_overrun;
        // live, a measurement is waiting
        status[lin_regs_pkg::STS_SYNC]    = ~fifo_empty;
    end

    assign interrupt = |(status & imask);

    // read mux
    always_comb
    begin
        case (wb_adr)
            lin_regs_pkg::ADDR_CTRL:   rd_data = lin_regs_pkg::WB_DW'(ctrl);
            lin_regs_pkg::ADDR_STATUS: rd_data = lin_regs_pkg::WB_DW'(status);
            lin_regs_pkg::ADDR_IMASK:  rd_data = lin_regs_pkg::WB_DW'(imask);
            default:                   rd_data = fifo_empty ? '0 : fifo_data;
        endcase
    end

    // bus handshake and writable registers
    always_ff @(posedge clk_fin)
    begin
        if (rst)
        begin
            wb_ack <= 1'b0;
            ctrl   <= '0;
            imask  <= '0;
        end
        else
        begin
            wb_ack <= req;
            if (wr_en && wb_adr == lin_regs_pkg::ADDR_CTRL)
            begin
                ctrl <= wb_dat_i[lin_regs_pkg::CTRL_RXD_DIS:0];
            end
            if (wr_en && wb_adr == lin_regs_pkg::ADDR_IMASK)
            begin
                imask <= wb_dat_i[lin_regs_pkg::STS_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_fin)
    begin
        if (rd_en)
        begin
            wb_dat_o <= rd_data;
        end
    end

    // sticky bits, write 1 clears, a new event wins
    always_ff @(posedge clk_fin)
    begin
        if (rst)
        begin
            sts_break   <= 1'b0;
            sts_edge    <= 1'b0;
            sts_overrun <= 1'b0;
        end
        else
        begin
            sts_break <= break_pulse |
                         (sts_break & ~(clr_sts & wb_dat_i[lin_regs_pkg::STS_BREAK]));
            sts_edge <= edge_pulse |
                        (sts_edge & ~(clr_sts & wb_dat_i[lin_regs_pkg::STS_EDGE]));
            sts_overrun <= overrun |
                           (sts_overrun & ~(clr_sts & wb_dat_i[lin_regs_pkg::STS_OVERRUN]));
        end
    end

    // rxd gate opens on a measurement, start low or rxd-disable closes it
    always_ff @(posedge clk_fin)
    begin
        if (rst)
        begin
            rxd_gate <= 1'b0;
        end
        else if (!ctrl[lin_regs_pkg::CTRL_START] || ctrl[lin_regs_pkg::CTRL_RXD_DIS])
        begin
            rxd_gate <= 1'b0;
        end
        else if (meas_valid)
        begin
            rxd_gate <= 1'b1;
        end
    end

    // registered pins
    always_ff @(posedge clk_fin)
    begin
        if (rst)
        begin
            rxd_out <= 1'b1;
            txd_out <= 1'b0;
        end
        else
        begin
            rxd_out <= rxd_gate ? rxd : 1'b1;
            txd_out <= ctrl[lin_regs_pkg::CTRL_TXD_DIS] ? 1'b0 : txd;
        end
    end

endmodule

// ==== src/lin_sync_fifo.sv ====
// circular buffer of synch measurements
// full buffer drops the push and flags overrun
`timescale 1ns/1ps

module lin_sync_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk_fin,
    input  logic                 rst,
    input  logic                 push,
    input  lin_proto_pkg::meas_t push_data,
    input  logic                 pop,
    output lin_proto_pkg::meas_t fifo_data,
    output logic                 fifo_empty,
    output logic                 overrun
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    lin_proto_pkg::meas_t mem [FIFO_DEPTH];
    logic [PW-1:0]        wr_ptr;
    logic [PW-1:0]        rd_ptr;
    logic [CW-1:0]        count;
    logic                 full;
    logic                 do_push;
    logic                 do_pop;

    assign fifo_empty = (count == '0);
    assign full       = (count == CW'(FIFO_DEPTH));
    assign do_pop     = pop & ~fifo_empty;
    // a pop in the same cycle frees the slot
    assign do_push    = push & (~full | do_pop);
    assign overrun    = push & ~do_push;
    assign fifo_data  = mem[rd_ptr];

    always_ff @(posedge clk_fin)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at FIFO_DEPTH, also for odd depths
    always_ff @(posedge clk_fin)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

endmodule
